// ==== sources.f ====
common/stream_pkg.sv
common/store_pkg.sv
addr_gen/addr_gen.sv
hdl/stream_credit_buf.sv
hdl/store_sink.sv
hdl/store_top.sv
testbench/tb_store_top.sv

// ==== Makefile ====
TOP       ?= tb_store_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_store_top.sv ====
module tb_store_top
   import stream_pkg::*;
   import store_pkg::*;
();

   localparam int unsigned DEPTH     = 4;
   localparam int unsigned SB_N      = 64;
   localparam int unsigned RUN_LIMIT = 2000;

   logic              clk_i;
   logic              rst_ni;
   logic              clear_i;
   logic              start_i;
   logic [ADDR_W-1:0] base_addr_i;
   logic [ADDR_W-1:0] stride_i;
   logic [LEN_W-1:0]  tot_len_i;
   logic              ready_start_o;
   logic              done_o;
   logic              in_valid_i;
   logic [DATA_W-1:0] in_data_i;
   logic [STRB_W-1:0] in_strb_i;
   logic              in_credit_o;
   logic              mem_req_o;
   logic              mem_gnt_i;
   logic [ADDR_W-1:0] mem_addr_o;
   logic [DATA_W-1:0] mem_wdata_o;
   logic [STRB_W-1:0] mem_be_o;

   // expected writes, filled when a transfer is set up
   logic [ADDR_W-1:0] sb_addr [SB_N];
   logic [DATA_W-1:0] sb_data [SB_N];
   logic [STRB_W-1:0] sb_be   [SB_N];
   logic [5:0]        sb_wr;
   logic [5:0]        sb_rd;
   logic [ADDR_W-1:0] exp_addr;
   logic [DATA_W-1:0] exp_data;
   logic [STRB_W-1:0] exp_be;

   // beats the source sends in the running transfer
   logic [DATA_W-1:0] beat_data [SB_N];
   logic [STRB_W-1:0] beat_strb [SB_N];

   logic [31:0] lfsr;
   int          grants;
   int          credits;
   int          errors;
   int          err_mark;
   int          tests_run;
   int          tests_failed;

   store_top #(
      .DATA_W        ( DATA_W ),
      .IN_FIFO_DEPTH ( DEPTH  )
   ) dut0 (
      .clk_i         ( clk_i         ),
      .rst_ni        ( rst_ni        ),
      .clear_i       ( clear_i       ),
      .start_i       ( start_i       ),
      .base_addr_i   ( base_addr_i   ),
      .stride_i      ( stride_i      ),
      .tot_len_i     ( tot_len_i     ),
      .ready_start_o ( ready_start_o ),
      .done_o        ( done_o        ),
      .in_valid_i    ( in_valid_i    ),
      .in_data_i     ( in_data_i     ),
      .in_strb_i     ( in_strb_i     ),
      .in_credit_o   ( in_credit_o   ),
      .mem_req_o     ( mem_req_o     ),
      .mem_gnt_i     ( mem_gnt_i     ),
      .mem_addr_o    ( mem_addr_o    ),
      .mem_wdata_o   ( mem_wdata_o   ),
      .mem_be_o      ( mem_be_o      )
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   assign exp_addr = sb_addr[sb_rd];
   assign exp_data = sb_data[sb_rd];
   assign exp_be   = sb_be[sb_rd];

   // scoreboard read side follows the granted writes
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         sb_rd  <= '0;
         grants <= 0;
      end else if (clear_i) begin
         sb_rd <= sb_wr;
      end else if (mem_req_o && mem_gnt_i) begin
         sb_rd  <= sb_rd + 1'b1;
         grants <= grants + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // checkers
   ////////////////////////////////////////////////////////////

   a_sb_not_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && mem_gnt_i) |-> (sb_rd != sb_wr))
   else begin
      $display("granted write with no expected write left");
      errors++;
   end

   a_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && mem_gnt_i) |-> (mem_addr_o == exp_addr))
   else begin
      $display("FAIL mem_addr_o: got %h, expected %h", $sampled(mem_addr_o), $sampled(exp_addr));
      errors++;
   end

   a_wdata : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && mem_gnt_i) |-> (mem_wdata_o == exp_data))
   else begin
      $display("FAIL mem_wdata_o: got %h, expected %h", $sampled(mem_wdata_o),
               $sampled(exp_data));
      errors++;
   end

   a_be : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && mem_gnt_i) |-> (mem_be_o == exp_be))
   else begin
      $display("FAIL mem_be_o: got %h, expected %h", $sampled(mem_be_o), $sampled(exp_be));
      errors++;
   end

   a_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && !mem_gnt_i && !clear_i) |=>
         (mem_req_o && $stable(mem_addr_o) && $stable(mem_wdata_o) && $stable(mem_be_o)))
   else begin
      $display("write request changed or dropped before its grant");
      errors++;
   end

   a_credits : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (credits >= 0) && (credits <= DEPTH))
   else begin
      $display("source credit count left its range");
      errors++;
   end

   a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |=> !done_o)
   else begin
      $display("done_o stayed high for more than one cycle");
      errors++;
   end

   a_ready_on_done : assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |-> ready_start_o)
   else begin
      $display("ready_start_o low while done_o is high");
      errors++;
   end

   a_clear : assert property (@(posedge clk_i) disable iff (!rst_ni)
      clear_i |=> (!mem_req_o && ready_start_o))
   else begin
      $display("clear did not return the unit to idle");
      errors++;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bit(output logic b);
      b    = lfsr[0];
      lfsr = lfsr_step(lfsr);
   endtask

   task automatic take_bits(input int n, output logic [31:0] v);
      logic b;
      v = '0;
      for (int i = 0; i < n; i++) begin
         take_bit(b);
         v[i] = b;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp) else begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // byte k of the word takes input byte k - offset
   task automatic push_expected(input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data,
                                input logic [STRB_W-1:0] strb);
      int                offs;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] be;
      offs  = int'(addr % STRB_W);
      wdata = '0;
      be    = '0;
      for (int k = offs; k < int'(STRB_W); k++) begin
         wdata[8*k +: 8] = data[8*(k-offs) +: 8];
         be[k]           = strb[k-offs];
      end
      sb_addr[sb_wr] = addr - ADDR_W'(offs);
      sb_data[sb_wr] = wdata;
      sb_be[sb_wr]   = be;
      sb_wr          = sb_wr + 1'b1;
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready_start_o && n < 100) begin
         @(posedge clk_i);
         #5;
         n++;
      end
      if (!ready_start_o) begin
         $display("timeout while waiting for ready_start_o");
         errors++;
      end
   endtask

   // one transfer, random grants and sends when stall is set,
   // a clear in cycle clear_at when it is nonzero
   task automatic run_transfer(input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] stride,
                               input int len, input bit stall, input int clear_at);
      logic [ADDR_W-1:0] a;
      logic [31:0]       v;
      logic              b;
      int                sent;
      int                returned;
      int                cyc;
      int                grants_at_start;
      bit                seen_done;
      bit                cleared;
      bit                send;
      a = base;
      for (int i = 0; i < len; i++) begin
         take_bits(DATA_W, v);
         beat_data[i] = v[DATA_W-1:0];
         take_bits(STRB_W, v);
         beat_strb[i] = v[STRB_W-1:0];
         push_expected(a, beat_data[i], beat_strb[i]);
         a = a + stride;
      end
      wait_ready();
      base_addr_i     = base;
      stride_i        = stride;
      tot_len_i       = LEN_W'(len);
      start_i         = 1'b1;
      grants_at_start = grants;
      sent            = 0;
      returned        = 0;
      cyc             = 0;
      seen_done       = 1'b0;
      cleared         = 1'b0;
      while (!seen_done && !cleared && cyc < RUN_LIMIT) begin
         @(posedge clk_i);
         #5;
         cyc++;
         start_i = 1'b0;
         if (in_credit_o) begin
            returned++;
            credits++;
         end
         seen_done = done_o;
         if (clear_at != 0 && cyc == clear_at) begin
            // flushed beats come back as a full credit count
            clear_i    = 1'b1;
            in_valid_i = 1'b0;
            mem_gnt_i  = 1'b0;
            credits    = DEPTH;
            cleared    = 1'b1;
         end else if (!seen_done) begin
            if (stall) begin
               take_bit(b);
               mem_gnt_i = b;
            end else begin
               mem_gnt_i = 1'b1;
            end
            send = (credits > 0) && (sent < len);
            if (send && stall) begin
               take_bit(b);
               send = b;
            end
            in_valid_i = send;
            if (send) begin
               in_data_i = beat_data[sent];
               in_strb_i = beat_strb[sent];
               credits--;
               sent++;
            end
         end
      end
      in_valid_i = 1'b0;
      mem_gnt_i  = 1'b0;
      if (cleared) begin
         @(posedge clk_i);
         #5;
         clear_i = 1'b0;
      end else if (!seen_done) begin
         $display("timeout while waiting for done_o");
         errors++;
      end else begin
         check_value("mem_gnt_i grant count", grants - grants_at_start, len);
         check_value("in_credit_o returns", returned, sent);
         check_value("source credits", credits, DEPTH);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed", tests_run, name);
      end
      err_mark = errors;
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_ni       = 1'b0;
      clear_i      = 1'b0;
      start_i      = 1'b0;
      base_addr_i  = '0;
      stride_i     = '0;
      tot_len_i    = '0;
      in_valid_i   = 1'b0;
      in_data_i    = '0;
      in_strb_i    = '0;
      mem_gnt_i    = 1'b0;
      sb_wr        = '0;
      lfsr         = 32'ha494_6dd9;
      credits      = DEPTH;
      errors       = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk_i);
      #5;
      rst_ni = 1'b1;

      check_value("mem_req_o", mem_req_o, 0);
      check_value("in_credit_o", in_credit_o, 0);
      check_value("done_o", done_o, 0);
      check_value("ready_start_o", ready_start_o, 1);
      finish_test("reset state");

      run_transfer(32'h1000_0000, 32'd4, 8, 1'b0, 0);
      finish_test("aligned transfer");

      for (int o = 1; o <= 3; o++) begin
         run_transfer(32'h1000_0100 + o, 32'd4, 4, 1'b0, 0);
      end
      finish_test("unaligned bases");

      run_transfer(32'h2000_0102, 32'd12, 10, 1'b1, 0);
      finish_test("grant stalls");

      run_transfer(32'h3000_0003, 32'd5, 12, 1'b1, 0);
      finish_test("credit accounting");

      run_transfer(32'h4000_0000, 32'd4, 8, 1'b1, 6);
      run_transfer(32'h4000_0100, 32'd4, 6, 1'b0, 0);
      finish_test("clear mid transfer");

      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== hdl/store_top.sv ====
module store_top
   import stream_pkg::*;
   import store_pkg::*;
#(
   parameter int unsigned DATA_W        = stream_pkg::DATA_W,
   parameter int unsigned IN_FIFO_DEPTH = 4
) (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              clear_i,
   input  logic              start_i,
   input  logic [ADDR_W-1:0] base_addr_i,
   input  logic [ADDR_W-1:0] stride_i,
   input  logic [LEN_W-1:0]  tot_len_i,
   output logic              ready_start_o,
   output logic              done_o,
   input  logic              in_valid_i,
   input  logic [DATA_W-1:0] in_data_i,
   input  logic [STRB_W-1:0] in_strb_i,
   output logic              in_credit_o,
   output logic              mem_req_o,
   input  logic              mem_gnt_i,
   output logic [ADDR_W-1:0] mem_addr_o,
   output logic [DATA_W-1:0] mem_wdata_o,
   output logic [STRB_W-1:0] mem_be_o
);

   // generator to sink
   logic [ADDR_W-1:0] addr;
   logic              addr_valid;
   logic              addr_ready;
   logic              gen_done;

   // buffer to sink
   logic              buf_valid;
   logic [DATA_W-1:0] buf_data;
   logic [STRB_W-1:0] buf_strb;
   logic              buf_pop;

   addr_gen i_addr_gen (
      .clk_i        ( clk_i       ),
      .rst_ni       ( rst_ni      ),
      .clear_i      ( clear_i     ),
      .start_i      ( start_i     ),
      .base_addr_i  ( base_addr_i ),
      .stride_i     ( stride_i    ),
      .tot_len_i    ( tot_len_i   ),
      .addr_o       ( addr        ),
      .addr_valid_o ( addr_valid  ),
      .addr_ready_i ( addr_ready  ),
      .gen_done_o   ( gen_done    )
   );

   stream_credit_buf #(
      .DATA_W        ( DATA_W        ),
      .IN_FIFO_DEPTH ( IN_FIFO_DEPTH )
   ) i_buf (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .clear_i     ( clear_i     ),
      .in_valid_i  ( in_valid_i  ),
      .in_data_i   ( in_data_i   ),
      .in_strb_i   ( in_strb_i   ),
      .in_credit_o ( in_credit_o ),
      .buf_valid_o ( buf_valid   ),
      .buf_data_o  ( buf_data    ),
      .buf_strb_o  ( buf_strb    ),
      .buf_pop_i   ( buf_pop     )
   );

   store_sink #(
      .DATA_W ( DATA_W )
   ) i_sink (
      .clk_i         ( clk_i         ),
      .rst_ni        ( rst_ni        ),
      .clear_i       ( clear_i       ),
      .start_i       ( start_i       ),
      .tot_len_i     ( tot_len_i     ),
      .ready_start_o ( ready_start_o ),
      .done_o        ( done_o        ),
      .addr_i        ( addr          ),
      .addr_valid_i  ( addr_valid    ),
      .addr_ready_o  ( addr_ready    ),
      .gen_done_i    ( gen_done      ),
      .buf_valid_i   ( buf_valid     ),
      .buf_data_i    ( buf_data      ),
      .buf_strb_i    ( buf_strb      ),
      .buf_pop_o     ( buf_pop       ),
      .mem_req_o     ( mem_req_o     ),
      .mem_gnt_i     ( mem_gnt_i     ),
      .mem_addr_o    ( mem_addr_o    ),
      .mem_wdata_o   ( mem_wdata_o   ),
      .mem_be_o      ( mem_be_o      )
   );

   // accepted start puts the sink to work and blocks further starts
   a_start_accepted : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (start_i && ready_start_o && !clear_i) |=>
         (!ready_start_o && (i_sink.state_q == SINK_WORKING))
   );

endmodule

// ==== hdl/store_sink.sv ====
module store_sink
   import stream_pkg::*;
   import store_pkg::*;
#(
   parameter int unsigned DATA_W = stream_pkg::DATA_W
) (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              clear_i,
   input  logic              start_i,
   input  logic [LEN_W-1:0]  tot_len_i,
   output logic              ready_start_o,
   output logic              done_o,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              addr_valid_i,
   output logic              addr_ready_o,
   input  logic              gen_done_i,
   input  logic              buf_valid_i,
   input  logic [DATA_W-1:0] buf_data_i,
   input  logic [STRB_W-1:0] buf_strb_i,
   output logic              buf_pop_o,
   output logic              mem_req_o,
   input  logic              mem_gnt_i,
   output logic [ADDR_W-1:0] mem_addr_o,
   output logic [DATA_W-1:0] mem_wdata_o,
   output logic [STRB_W-1:0] mem_be_o
);

   sink_state_e       state_q;
   sink_state_e       state_d;
   logic [LEN_W-1:0]  cnt_q;
   logic [LEN_W-1:0]  cnt_inc;
   logic [OFFS_W-1:0] offs;
   logic              write;
   logic              done_q;
   logic              done_d;

   ////////////////////////////////////////////////////////////
   // pairing and alignment
   ////////////////////////////////////////////////////////////

   assign offs = addr_i[OFFS_W-1:0];

   // request only with both halves of the pair present
   assign mem_req_o   = (state_q != SINK_IDLE) & addr_valid_i & buf_valid_i;
   assign mem_addr_o  = {addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
   // lanes below the offset stay empty and bytes past the top fall off
   assign mem_be_o    = buf_strb_i << offs;
   assign mem_wdata_o = buf_data_i << {offs, 3'b000};

   // a grant consumes the address and the beat together
   assign write        = mem_req_o & mem_gnt_i;
   assign addr_ready_o = write;
   assign buf_pop_o    = write;

   assign cnt_inc = cnt_q + 1'b1;

   assign ready_start_o = (state_q == SINK_IDLE);
   assign done_o        = done_q;

   ////////////////////////////////////////////////////////////
   // control FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      done_d  = 1'b0;
      case (state_q)
         SINK_IDLE: begin
            if (start_i) begin
               state_d = SINK_WORKING;
            end
         end
         SINK_WORKING: begin
            // generator stops with the last granted pair
            if (gen_done_i) begin
               state_d = SINK_DRAIN;
            end
         end
         SINK_DRAIN: begin
            if (cnt_q == tot_len_i) begin
               state_d = SINK_IDLE;
               done_d  = 1'b1;
            end
         end
         default: state_d = SINK_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= SINK_IDLE;
         done_q  <= 1'b0;
         cnt_q   <= '0;
      end else if (clear_i) begin
         state_q <= SINK_IDLE;
         done_q  <= 1'b0;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         done_q  <= done_d;
         if (ready_start_o && start_i) begin
            cnt_q <= '0;
         end else if (write) begin
            cnt_q <= cnt_inc;
         end
      end
   end

   // waiting request holds address, data and enables until granted
   a_req_stable : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && !mem_gnt_i && !clear_i) |=>
         (mem_req_o && $stable(mem_addr_o) && $stable(mem_wdata_o) && $stable(mem_be_o))
   );

endmodule

// ==== hdl/stream_credit_buf.sv ====
module stream_credit_buf
   import stream_pkg::*;
#(
   parameter int unsigned DATA_W        = stream_pkg::DATA_W,
   parameter int unsigned IN_FIFO_DEPTH = 4
) (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              clear_i,
   input  logic              in_valid_i,
   input  logic [DATA_W-1:0] in_data_i,
   input  logic [STRB_W-1:0] in_strb_i,
   output logic              in_credit_o,
   output logic              buf_valid_o,
   output logic [DATA_W-1:0] buf_data_o,
   output logic [STRB_W-1:0] buf_strb_o,
   input  logic              buf_pop_i
);

   localparam int unsigned PTR_W = $clog2(IN_FIFO_DEPTH);

   logic [DATA_W-1:0] data_q [IN_FIFO_DEPTH];
   logic [STRB_W-1:0] strb_q [IN_FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CRED_W-1:0] fill_q;
   logic              credit_q;
   logic              push;
   logic              pop;

   // circular pointer, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(IN_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // no ready toward the source, credits guarantee room
   assign push = in_valid_i;
   assign pop  = buf_pop_i & buf_valid_o;

   assign buf_valid_o = (fill_q != '0);
   assign buf_data_o  = data_q[rd_ptr_q];
   assign buf_strb_o  = strb_q[rd_ptr_q];
   assign in_credit_o = credit_q;

   ////////////////////////////////////////////////////////////
   // pointers, fill level and credit return
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         credit_q <= 1'b0;
      end else if (clear_i) begin
         // flushed entries give no credit back
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         credit_q <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         if (push && !pop) begin
            fill_q <= fill_q + 1'b1;
         end else if (pop && !push) begin
            fill_q <= fill_q - 1'b1;
         end
         // one credit per beat handed to the sink
         credit_q <= pop;
      end
   end

   // storage
   always_ff @(posedge clk_i) begin
      if (push) begin
         data_q[wr_ptr_q] <= in_data_i;
         strb_q[wr_ptr_q] <= in_strb_i;
      end
   end

   // a source that spends only its credits never hits a full FIFO
   a_no_push_when_full : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (in_valid_i && !clear_i) |-> (fill_q != CRED_W'(IN_FIFO_DEPTH))
   );

endmodule

// ==== addr_gen/addr_gen.sv ====
module addr_gen
   import store_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              clear_i,
   input  logic              start_i,
   input  logic [ADDR_W-1:0] base_addr_i,
   input  logic [ADDR_W-1:0] stride_i,
   input  logic [LEN_W-1:0]  tot_len_i,
   output logic [ADDR_W-1:0] addr_o,
   output logic              addr_valid_o,
   input  logic              addr_ready_i,
   output logic              gen_done_o
);

   logic [ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]  cnt_q;
   logic [LEN_W-1:0]  cnt_next;
   logic              valid_q;
   logic              load;
   logic              accept;
   logic              last;

   // a new pattern is only loaded while nothing is pending
   assign load     = start_i & ~valid_q;
   assign accept   = valid_q & addr_ready_i;
   assign cnt_next = cnt_q + 1'b1;
   assign last     = (cnt_next == tot_len_i);

   assign addr_o       = addr_q;
   assign addr_valid_o = valid_q;
   assign gen_done_o   = accept & last;

   ////////////////////////////////////////////////////////////
   // issue control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         valid_q <= 1'b0;
         cnt_q   <= '0;
      end else if (clear_i) begin
         valid_q <= 1'b0;
         cnt_q   <= '0;
      end else if (load) begin
         // zero length transfer issues nothing
         valid_q <= (tot_len_i != '0);
         cnt_q   <= '0;
      end else if (accept) begin
         cnt_q <= cnt_next;
         if (last) begin
            valid_q <= 1'b0;
         end
      end
   end

   // output address register
   always_ff @(posedge clk_i) begin
      if (load) begin
         addr_q <= base_addr_i;
      end else if (accept) begin
         addr_q <= addr_q + stride_i;
      end
   end

   // while an address is offered, fewer than tot_len have gone out
   a_cnt_in_range : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      addr_valid_o |-> (cnt_q < tot_len_i)
   );

endmodule

// ==== common/store_pkg.sv ====
package store_pkg;

   ////////////////////////////////////////////////////////////
   // address pattern
   ////////////////////////////////////////////////////////////

   // byte address seen by the generator and the memory port
   localparam int unsigned ADDR_W = 32;

   // beat count per transfer and completed write count
   localparam int unsigned LEN_W = 16;

   ////////////////////////////////////////////////////////////
   // sink control
   ////////////////////////////////////////////////////////////

   // idle      waiting for start, ready_start high
   // working   addresses still coming from the generator
   // drain     generator finished, waiting on the last writes
   typedef enum logic [1:0] {
      SINK_IDLE    = 2'b00,
      SINK_WORKING = 2'b01,
      SINK_DRAIN   = 2'b10
   } sink_state_e;

endpackage

// ==== common/stream_pkg.sv ====
package stream_pkg;

   ////////////////////////////////////////////////////////////
   // data path
   ////////////////////////////////////////////////////////////

   // default beat and memory word width
   localparam int unsigned DATA_W = 32;

   // one strobe per byte lane
   localparam int unsigned STRB_W = DATA_W / 8;

   // byte offset inside a word
   localparam int unsigned OFFS_W = $clog2(STRB_W);

   ////////////////////////////////////////////////////////////
   // flow control
   ////////////////////////////////////////////////////////////

   // credit and fill counters, enough for buffers up to 8 deep
   localparam int unsigned CRED_W = 4;

endpackage
